/* rtl/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// operand and result width
`define EXEC_XLEN 64
// execution lanes feeding the memory stage
`define EXEC_LANES 4
// lane index that holds the pipelined multiplier
`define EXEC_MUL_LANE 2
// reorder-buffer size and the tag width derived from it
`define EXEC_ROB_SIZE 32
`define EXEC_TAG_W ($clog2(`EXEC_ROB_SIZE) + 1)
`define EXEC_CMD_W 10
// result buffer depths; mul covers three stages in flight plus one
`define EXEC_ALU_DEPTH 2
`define EXEC_MUL_DEPTH 4

`endif

/* rtl/exec_cmd_pkg.sv */
package exec_cmd_pkg;

  // alu operation codes, upper four bits of the alu view
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // alu view of the command word
  typedef struct packed {
    alu_op_e    op;
    // set: shift amount limited to b[4:0], clear: b[5:0]
    logic       imm_shift;
    logic [4:0] rd;
  } alu_cmd_t;

  // multiplier view of the command word
  typedef struct packed {
    // set returns the upper 64 bits of the product
    logic       high;
    logic       signed_a;
    logic       signed_b;
    logic [1:0] spare;
    logic [4:0] rd;
  } mul_cmd_t;

  // one 10-bit word, decoded by whichever lane receives it
  typedef union packed {
    alu_cmd_t alu;
    mul_cmd_t mul;
  } exec_cmd_u;

endpackage

/* rtl/exec_pipe_pkg.sv */
`include "exec_params.svh"

package exec_pipe_pkg;

  // condition flags produced by every lane
  typedef struct packed {
    logic zero;
    logic negative;
    // borrow for sub, carry out for add
    logic carry;
    logic overflow;
  } exec_flags_t;

  // one finished operation as it travels to the memory stage
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]  value;
    logic [`EXEC_TAG_W-1:0] tag;
    exec_cmd_pkg::exec_cmd_u cmd;
    exec_flags_t            flags;
  } exec_result_t;

endpackage

/* rtl/exec_result_if.sv */
`timescale 1ns/100ps

// head of one lane's result buffer as seen by the output select
interface exec_result_if;

  // head entry present
  logic valid;
  // one-cycle grant, pops the head at the next edge
  logic can_go;
  exec_pipe_pkg::exec_result_t result;

  modport buffer (
    output valid,
    output result,
    input  can_go
  );

  modport select (
    input  valid,
    input  result,
    output can_go
  );

endinterface

/* rtl/exec_issue_stage.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_issue_stage (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [`EXEC_LANES-1:0]                    issue_valid_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_TAG_W-1:0]   issue_tag_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_CMD_W-1:0]   issue_cmd_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]    issue_a_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]    issue_b_i,
  input  logic [`EXEC_LANES-1:0]                    grant_i,
  output logic [`EXEC_LANES-1:0]                    lane_full_o,
  output logic [`EXEC_LANES-1:0]                    op_valid_o,
  output logic [`EXEC_LANES-1:0][`EXEC_TAG_W-1:0]   op_tag_o,
  output exec_cmd_pkg::exec_cmd_u [`EXEC_LANES-1:0] op_cmd_o,
  output logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]    op_a_o,
  output logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]    op_b_o
);

  // wide enough for the deepest buffer
  localparam int CRED_W = $clog2(`EXEC_MUL_DEPTH + 1);

  for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_lane
    localparam int DEPTH = (l == `EXEC_MUL_LANE) ? `EXEC_MUL_DEPTH : `EXEC_ALU_DEPTH;

    logic [CRED_W-1:0]       credit_q;
    logic                    accept;
    logic                    valid_q;
    logic [`EXEC_TAG_W-1:0]  tag_q;
    exec_cmd_pkg::exec_cmd_u cmd_q;
    logic [`EXEC_XLEN-1:0]   a_q;
    logic [`EXEC_XLEN-1:0]   b_q;

    // an issue to a full lane is dropped and costs nothing
    assign accept = issue_valid_i[l] & (credit_q != '0);

    // one credit per buffer slot, returned when the select pops the head
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        credit_q <= CRED_W'(DEPTH);
        valid_q  <= 1'b0;
      end else begin
        valid_q <= accept;
        case ({accept, grant_i[l]})
          2'b10:   credit_q <= credit_q - 1'b1;
          2'b01:   credit_q <= credit_q + 1'b1;
          default: credit_q <= credit_q;
        endcase
      end
    end

    // operand registers, only loaded on an accepted issue
    always_ff @(posedge clk_i) begin
      if (accept) begin
        tag_q <= issue_tag_i[l];
        cmd_q <= issue_cmd_i[l];
        a_q   <= issue_a_i[l];
        b_q   <= issue_b_i[l];
      end
    end

    assign lane_full_o[l] = (credit_q == '0);
    assign op_valid_o[l]  = valid_q;
    assign op_tag_o[l]    = tag_q;
    assign op_cmd_o[l]    = cmd_q;
    assign op_a_o[l]      = a_q;
    assign op_b_o[l]      = b_q;
  end

endmodule

/* rtl/exec_alu.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_alu (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        op_valid_i,
  input  logic [`EXEC_TAG_W-1:0]      op_tag_i,
  input  exec_cmd_pkg::exec_cmd_u     op_cmd_i,
  input  logic [`EXEC_XLEN-1:0]       op_a_i,
  input  logic [`EXEC_XLEN-1:0]       op_b_i,
  output logic                        wr_o,
  output exec_pipe_pkg::exec_result_t wr_result_o
);

  localparam int MSB = `EXEC_XLEN - 1;

  logic [`EXEC_XLEN:0]        sum;
  logic [5:0]                 shamt;
  logic [`EXEC_XLEN-1:0]      value;
  exec_pipe_pkg::exec_flags_t flags;

  always_comb begin
    // word-sized shift when the immediate flag is set
    shamt = op_cmd_i.alu.imm_shift ? {1'b0, op_b_i[4:0]} : op_b_i[5:0];
    sum   = '0;
    value = '0;
    flags = '0;
    case (op_cmd_i.alu.op)
      exec_cmd_pkg::ALU_ADD: begin
        sum            = {1'b0, op_a_i} + {1'b0, op_b_i};
        value          = sum[MSB:0];
        flags.carry    = sum[`EXEC_XLEN];
        flags.overflow = (op_a_i[MSB] == op_b_i[MSB]) && (value[MSB] != op_a_i[MSB]);
      end
      exec_cmd_pkg::ALU_SUB: begin
        // top bit of the wide difference is the borrow
        sum            = {1'b0, op_a_i} - {1'b0, op_b_i};
        value          = sum[MSB:0];
        flags.carry    = sum[`EXEC_XLEN];
        flags.overflow = (op_a_i[MSB] != op_b_i[MSB]) && (value[MSB] != op_a_i[MSB]);
      end
      exec_cmd_pkg::ALU_AND:  value = op_a_i & op_b_i;
      exec_cmd_pkg::ALU_OR:   value = op_a_i | op_b_i;
      exec_cmd_pkg::ALU_XOR:  value = op_a_i ^ op_b_i;
      exec_cmd_pkg::ALU_SLL:  value = op_a_i << shamt;
      exec_cmd_pkg::ALU_SRL:  value = op_a_i >> shamt;
      exec_cmd_pkg::ALU_SRA:  value = $signed(op_a_i) >>> shamt;
      exec_cmd_pkg::ALU_SLT:  value = {{MSB{1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      exec_cmd_pkg::ALU_SLTU: value = {{MSB{1'b0}}, op_a_i < op_b_i};
      // unused codes return zero
      default: value = '0;
    endcase
    flags.zero     = (value == '0);
    flags.negative = value[MSB];
  end

  // write strobe follows the op by one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_o <= 1'b0;
    end else begin
      wr_o <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      wr_result_o.value <= value;
      wr_result_o.tag   <= op_tag_i;
      wr_result_o.cmd   <= op_cmd_i;
      wr_result_o.flags <= flags;
    end
  end

endmodule

/* rtl/exec_multiplier.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_multiplier (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        op_valid_i,
  input  logic [`EXEC_TAG_W-1:0]      op_tag_i,
  input  exec_cmd_pkg::exec_cmd_u     op_cmd_i,
  input  logic [`EXEC_XLEN-1:0]       op_a_i,
  input  logic [`EXEC_XLEN-1:0]       op_b_i,
  output logic                        wr_o,
  output exec_pipe_pkg::exec_result_t wr_result_o
);

  localparam int XL = `EXEC_XLEN;

  // stage 1 holds the operands widened by one sign bit
  logic                    s1_valid, s2_valid;
  logic [`EXEC_TAG_W-1:0]  s1_tag, s2_tag;
  exec_cmd_pkg::exec_cmd_u s1_cmd, s2_cmd;
  logic signed [XL:0]      s1_a, s1_b;
  // full signed product, only the low 2*XL bits are meaningful
  logic signed [2*XL+1:0]  full_prod;
  logic [2*XL-1:0]         s2_prod;
  logic [XL-1:0]           kept, dropped;

  assign full_prod = s1_a * s1_b;

  // stage 3 picks the half and derives flags
  assign kept    = s2_cmd.mul.high ? s2_prod[2*XL-1:XL] : s2_prod[XL-1:0];
  assign dropped = s2_cmd.mul.high ? s2_prod[XL-1:0] : s2_prod[2*XL-1:XL];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      wr_o     <= 1'b0;
    end else begin
      s1_valid <= op_valid_i;
      s2_valid <= s1_valid;
      wr_o     <= s2_valid;
    end
  end

  // payload travels alongside the valid bits
  always_ff @(posedge clk_i) begin
    s1_tag  <= op_tag_i;
    s1_cmd  <= op_cmd_i;
    s1_a    <= {op_cmd_i.mul.signed_a & op_a_i[XL-1], op_a_i};
    s1_b    <= {op_cmd_i.mul.signed_b & op_b_i[XL-1], op_b_i};
    s2_tag  <= s1_tag;
    s2_cmd  <= s1_cmd;
    s2_prod <= full_prod[2*XL-1:0];
    wr_result_o.value          <= kept;
    wr_result_o.tag            <= s2_tag;
    wr_result_o.cmd            <= s2_cmd;
    wr_result_o.flags.zero     <= (kept == '0);
    wr_result_o.flags.negative <= kept[XL-1];
    wr_result_o.flags.carry    <= 1'b0;
    // other half not a pure sign extension of the kept half
    wr_result_o.flags.overflow <= (dropped != {XL{kept[XL-1]}});
  end

endmodule

/* rtl/exec_result_buffer.sv */
`timescale 1ns/100ps

module exec_result_buffer #(
  parameter int DEPTH = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        wr_i,
  input  exec_pipe_pkg::exec_result_t wr_result_i,
  exec_result_if.buffer               head
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  exec_pipe_pkg::exec_result_t mem [DEPTH];
  logic [PTR_W-1:0]            wr_ptr, rd_ptr;
  logic [CNT_W-1:0]            count;
  logic                        pop;

  // issue credits keep writes away from a full buffer
  assign pop         = head.can_go & head.valid;
  assign head.valid  = (count != '0);
  assign head.result = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({wr_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem[wr_ptr] <= wr_result_i;
    end
  end

endmodule

/* rtl/execute_output_select.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module execute_output_select (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  exec_result_if.select          lane0,
  exec_result_if.select          lane1,
  exec_result_if.select          lane2,
  exec_result_if.select          lane3,
  output logic                   mem_valid_o,
  output logic [`EXEC_XLEN-1:0]  mem_data_o,
  output logic [`EXEC_TAG_W-1:0] mem_tag_o,
  output logic [`EXEC_CMD_W-1:0] mem_cmd_o,
  output logic [3:0]             mem_flags_o
);

  logic [3:0]                  valid;
  logic [3:0]                  grant;
  exec_pipe_pkg::exec_result_t pick;

  assign valid = {lane3.valid, lane2.valid, lane1.valid, lane0.valid};

  // one-hot grant, highest lane wins
  assign grant[3] = valid[3];
  assign grant[2] = valid[2] & ~valid[3];
  assign grant[1] = valid[1] & ~|valid[3:2];
  assign grant[0] = valid[0] & ~|valid[3:1];

  assign lane3.can_go = grant[3];
  assign lane2.can_go = grant[2];
  assign lane1.can_go = grant[1];
  assign lane0.can_go = grant[0];

  // lane 0 is the fallthrough, only captured when granted
  always_comb begin
    if (grant[3]) pick = lane3.result;
    else if (grant[2]) pick = lane2.result;
    else if (grant[1]) pick = lane1.result;
    else pick = lane0.result;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_valid_o <= 1'b0;
    end else begin
      mem_valid_o <= |grant;
    end
  end

  // memory-stage payload register
  always_ff @(posedge clk_i) begin
    if (|grant) begin
      mem_data_o  <= pick.value;
      mem_tag_o   <= pick.tag;
      mem_cmd_o   <= pick.cmd;
      mem_flags_o <= pick.flags;
    end
  end

endmodule

/* rtl/execute_stage_top.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module execute_stage_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [`EXEC_LANES-1:0]                  issue_valid_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_TAG_W-1:0] issue_tag_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_CMD_W-1:0] issue_cmd_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]  issue_a_i,
  input  logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]  issue_b_i,
  output logic [`EXEC_LANES-1:0]                  lane_full_o,
  output logic                                    mem_valid_o,
  output logic [`EXEC_XLEN-1:0]                   mem_data_o,
  output logic [`EXEC_TAG_W-1:0]                  mem_tag_o,
  output logic [`EXEC_CMD_W-1:0]                  mem_cmd_o,
  output logic [3:0]                              mem_flags_o
);

  logic [`EXEC_LANES-1:0]                    grant;
  logic [`EXEC_LANES-1:0]                    op_valid;
  logic [`EXEC_LANES-1:0][`EXEC_TAG_W-1:0]   op_tag;
  exec_cmd_pkg::exec_cmd_u [`EXEC_LANES-1:0] op_cmd;
  logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]    op_a;
  logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]    op_b;
  logic [`EXEC_LANES-1:0]                    wr;
  exec_pipe_pkg::exec_result_t               wr_result [`EXEC_LANES];

  // one result head per lane
  exec_result_if lane_if [`EXEC_LANES] ();

  exec_issue_stage u_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_tag_i   (issue_tag_i),
    .issue_cmd_i   (issue_cmd_i),
    .issue_a_i     (issue_a_i),
    .issue_b_i     (issue_b_i),
    .grant_i       (grant),
    .lane_full_o   (lane_full_o),
    .op_valid_o    (op_valid),
    .op_tag_o      (op_tag),
    .op_cmd_o      (op_cmd),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_lane
    localparam int DEPTH = (l == `EXEC_MUL_LANE) ? `EXEC_MUL_DEPTH : `EXEC_ALU_DEPTH;

    // lane 2 multiplies, the rest are single-cycle alus
    if (l == `EXEC_MUL_LANE) begin : g_mul
      exec_multiplier u_mul (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .op_valid_i (op_valid[l]), .op_tag_i (op_tag[l]), .op_cmd_i (op_cmd[l]),
        .op_a_i (op_a[l]), .op_b_i (op_b[l]),
        .wr_o (wr[l]), .wr_result_o (wr_result[l])
      );
    end else begin : g_alu
      exec_alu u_alu (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .op_valid_i (op_valid[l]), .op_tag_i (op_tag[l]), .op_cmd_i (op_cmd[l]),
        .op_a_i (op_a[l]), .op_b_i (op_b[l]),
        .wr_o (wr[l]), .wr_result_o (wr_result[l])
      );
    end

    exec_result_buffer #(.DEPTH(DEPTH)) u_buf (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wr_i        (wr[l]),
      .wr_result_i (wr_result[l]),
      .head        (lane_if[l])
    );

    // the pop also returns a credit to the issue stage
    assign grant[l] = lane_if[l].can_go;
  end

  execute_output_select u_select (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lane0       (lane_if[0]),
    .lane1       (lane_if[1]),
    .lane2       (lane_if[2]),
    .lane3       (lane_if[3]),
    .mem_valid_o (mem_valid_o),
    .mem_data_o  (mem_data_o),
    .mem_tag_o   (mem_tag_o),
    .mem_cmd_o   (mem_cmd_o),
    .mem_flags_o (mem_flags_o)
  );

endmodule

/* testbench/tb_execute_stage.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module tb_execute_stage;

  localparam int CLK_PERIOD  = 100;
  localparam int RAND_CYCLES = 48;
  // directed ops plus up to four issues per random cycle
  localparam int PLANNED_OPS = 20 + 8 + 3 + 1 + 3 + 4 * RAND_CYCLES;
  localparam int WATCHDOG_CYCLES = PLANNED_OPS * 10 + 200;

  logic                        clk;
  logic                        rst_n;
  logic [3:0]                  issue_valid;
  logic [3:0][`EXEC_TAG_W-1:0] issue_tag;
  logic [3:0][`EXEC_CMD_W-1:0] issue_cmd;
  logic [3:0][63:0]            issue_a;
  logic [3:0][63:0]            issue_b;
  logic [3:0]                  lane_full;
  logic                        mem_valid;
  logic [63:0]                 mem_data;
  logic [`EXEC_TAG_W-1:0]      mem_tag;
  logic [`EXEC_CMD_W-1:0]      mem_cmd;
  logic [3:0]                  mem_flags;

  logic [15:0]            lfsr;
  logic [`EXEC_TAG_W-1:0] tag_ctr;
  // next op per lane as loaded by set_lane_op
  logic [`EXEC_TAG_W-1:0] nxt_tag [4];
  logic [`EXEC_CMD_W-1:0] nxt_cmd [4];
  logic [63:0]            nxt_a [4];
  logic [63:0]            nxt_b [4];
  // scoreboard keyed by tag
  logic [63:0] exp_value [int];
  logic [3:0]  exp_flags [int];
  logic [9:0]  exp_cmd [int];
  int          issue_cycle [int];
  int          arrive_cycle [int];
  bit          pending [int];
  bit          dropped [int];
  int          cycle = 0;
  int          errors = 0;
  int          issued = 0;
  int          results = 0;
  int          drops = 0;

  execute_stage_top uut (
    .clk_i (clk), .rst_n_i (rst_n),
    .issue_valid_i (issue_valid), .issue_tag_i (issue_tag), .issue_cmd_i (issue_cmd),
    .issue_a_i (issue_a), .issue_b_i (issue_b), .lane_full_o (lane_full),
    .mem_valid_o (mem_valid), .mem_data_o (mem_data), .mem_tag_o (mem_tag),
    .mem_cmd_o (mem_cmd), .mem_flags_o (mem_flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic void flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endfunction

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // expected {value, zero, negative, carry, overflow} of an alu op
  function automatic logic [67:0] alu_model(input logic [9:0] cmd, input logic [63:0] a, b);
    logic [5:0]  sh;
    logic [63:0] v;
    logic [64:0] sx;
    logic        c;
    logic        ov;
    sh = cmd[5] ? {1'b0, b[4:0]} : b[5:0];
    c  = 1'b0;
    ov = 1'b0;
    case (cmd[9:6])
      exec_cmd_pkg::ALU_ADD: begin
        v  = a + b;
        c  = (v < a);
        // signed sum one bit wider never wraps
        sx = {a[63], a} + {b[63], b};
        ov = (sx[64] != sx[63]);
      end
      exec_cmd_pkg::ALU_SUB: begin
        // carry is the borrow
        v  = a - b;
        c  = (a < b);
        sx = {a[63], a} - {b[63], b};
        ov = (sx[64] != sx[63]);
      end
      exec_cmd_pkg::ALU_AND:  v = a & b;
      exec_cmd_pkg::ALU_OR:   v = a | b;
      exec_cmd_pkg::ALU_XOR:  v = a ^ b;
      exec_cmd_pkg::ALU_SLL:  v = a << sh;
      exec_cmd_pkg::ALU_SRL:  v = a >> sh;
      exec_cmd_pkg::ALU_SRA:  v = a[63] ? ~(~a >> sh) : (a >> sh);
      exec_cmd_pkg::ALU_SLT:  v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      exec_cmd_pkg::ALU_SLTU: v = (a < b) ? 64'd1 : 64'd0;
      default:                v = '0;
    endcase
    return {v, (v == 64'd0), v[63], c, ov};
  endfunction

  // full 128-bit product of the extended operands then one half picked
  function automatic logic [67:0] mul_model(input logic [9:0] cmd, input logic [63:0] a, b);
    logic [127:0] p;
    logic [63:0]  kept;
    logic [63:0]  other;
    p     = {{64{cmd[8] & a[63]}}, a} * {{64{cmd[7] & b[63]}}, b};
    kept  = cmd[9] ? p[127:64] : p[63:0];
    other = cmd[9] ? p[63:0] : p[127:64];
    return {kept, (kept == 64'd0), kept[63], 1'b0, (other != {64{kept[63]}})};
  endfunction

  task automatic set_lane_op(input int l, input logic [9:0] cmd, input logic [63:0] a, b,
                             output int tag);
    nxt_tag[l] = tag_ctr;
    nxt_cmd[l] = cmd;
    nxt_a[l]   = a;
    nxt_b[l]   = b;
    tag        = int'(tag_ctr);
    tag_ctr    = tag_ctr + 1'b1;
  endtask

  // drive one issue cycle and record what the lanes accept
  task automatic drive_cycle(input logic [3:0] v, output logic [3:0] acc);
    logic [67:0] res;
    int          t;
    @(posedge clk);
    issue_valid <= v;
    issue_tag   <= {nxt_tag[3], nxt_tag[2], nxt_tag[1], nxt_tag[0]};
    issue_cmd   <= {nxt_cmd[3], nxt_cmd[2], nxt_cmd[1], nxt_cmd[0]};
    issue_a     <= {nxt_a[3], nxt_a[2], nxt_a[1], nxt_a[0]};
    issue_b     <= {nxt_b[3], nxt_b[2], nxt_b[1], nxt_b[0]};
    // credits hold still until the edge that samples this issue
    @(negedge clk);
    acc = v & ~lane_full;
    for (int l = 0; l < 4; l++) begin
      if (v[l]) begin
        t = int'(nxt_tag[l]);
        if (acc[l]) begin
          res = (l == `EXEC_MUL_LANE) ? mul_model(nxt_cmd[l], nxt_a[l], nxt_b[l])
                                      : alu_model(nxt_cmd[l], nxt_a[l], nxt_b[l]);
          exp_value[t]   = res[67:4];
          exp_flags[t]   = res[3:0];
          exp_cmd[t]     = nxt_cmd[l];
          pending[t]     = 1'b1;
          issue_cycle[t] = cycle + 1;
          dropped.delete(t);
          issued++;
        end else begin
          dropped[t] = 1'b1;
          drops++;
        end
      end
    end
  endtask

  task automatic wait_drained(input int limit);
    logic [3:0] acc;
    for (int n = 0; n < limit && pending.num() != 0; n++) drive_cycle(4'b0000, acc);
    drive_cycle(4'b0000, acc);
  endtask

  // scoreboard check on every memory-stage result
  always @(negedge clk) begin : monitor
    int t;
    if (rst_n && mem_valid) begin
      t = int'(mem_tag);
      results++;
      assert (!dropped.exists(t))
        else flag_error($sformatf("tag %0d of an ignored issue reached memory", t));
      assert (pending.exists(t)) else flag_error($sformatf("tag %0d not outstanding", t));
      if (pending.exists(t)) begin
        assert (mem_data == exp_value[t])
          else flag_error($sformatf("tag %0d data %h exp %h", t, mem_data, exp_value[t]));
        assert (mem_flags == exp_flags[t])
          else flag_error($sformatf("tag %0d flags %b exp %b", t, mem_flags, exp_flags[t]));
        assert (mem_cmd == exp_cmd[t])
          else flag_error($sformatf("tag %0d cmd %h exp %h", t, mem_cmd, exp_cmd[t]));
        arrive_cycle[t] = cycle;
        pending.delete(t);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin : stimulus
    logic [3:0]  acc;
    logic [3:0]  mask;
    logic [3:0]  prev;
    logic [63:0] r;
    logic [63:0] a;
    logic [63:0] b;
    logic [9:0]  cmd;
    int          t0, t1, t3, tm;
    int          lane;
    rst_n       = 1'b0;
    issue_valid = '0;
    issue_tag   = '0;
    issue_cmd   = '0;
    issue_a     = '0;
    issue_b     = '0;
    lfsr        = 16'd71;
    tag_ctr     = '0;
    for (int l = 0; l < 4; l++) begin
      nxt_tag[l] = '0;
      nxt_cmd[l] = '0;
      nxt_a[l]   = '0;
      nxt_b[l]   = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (!mem_valid && lane_full == 4'b0000) else flag_error("outputs not idle in reset");
    @(posedge clk);
    rst_n <= 1'b1;

    // every alu op spread over lanes 0 1 3 and a second pass with equal operands
    for (int pass = 0; pass < 2; pass++) begin
      for (int op = 0; op < 10; op++) begin
        draw_bits(64, a);
        if (pass == 1) b = a;
        else draw_bits(64, b);
        lane = (op % 3 == 2) ? 3 : op % 3;
        set_lane_op(lane, {4'(op), 1'(pass), 5'(op)}, a, b, t0);
        mask = '0;
        mask[lane] = 1'b1;
        drive_cycle(mask, acc);
        assert (acc == mask) else flag_error($sformatf("alu op %0d not accepted", op));
      end
    end
    wait_drained(50);

    // two batches of four back-to-back multiplies cover all sign and half choices
    for (int i = 0; i < 8; i++) begin
      draw_bits(64, a);
      if (i < 4) begin
        draw_bits(64, b);
      end else begin
        draw_bits(16, b);
        b = {{48{b[15]}}, b[15:0]};
      end
      set_lane_op(2, {3'(i), 2'b00, 5'(i)}, a, b, tm);
      drive_cycle(4'b0100, acc);
      assert (acc == 4'b0100) else flag_error($sformatf("multiply %0d not accepted", i));
      if (i == 3) wait_drained(50);
    end
    wait_drained(50);

    // lanes 0 1 3 together with nothing else pending
    draw_bits(64, a);
    draw_bits(64, b);
    set_lane_op(0, {exec_cmd_pkg::ALU_ADD, 6'd1}, a, b, t0);
    set_lane_op(1, {exec_cmd_pkg::ALU_XOR, 6'd2}, a, b, t1);
    set_lane_op(3, {exec_cmd_pkg::ALU_SUB, 6'd3}, a, b, t3);
    drive_cycle(4'b1011, acc);
    wait_drained(50);
    assert (arrive_cycle.exists(t0) && arrive_cycle.exists(t1) && arrive_cycle.exists(t3))
      else flag_error("priority group did not return");
    assert (arrive_cycle[t3] - issue_cycle[t3] == 3)
      else flag_error($sformatf("lane 3 latency %0d", arrive_cycle[t3] - issue_cycle[t3]));
    assert (arrive_cycle[t1] == arrive_cycle[t3] + 1 && arrive_cycle[t0] == arrive_cycle[t1] + 1)
      else flag_error("priority order is not lane 3, lane 1, lane 0");

    // lone multiply latency
    draw_bits(64, a);
    draw_bits(64, b);
    set_lane_op(2, 10'b1100000111, a, b, tm);
    drive_cycle(4'b0100, acc);
    wait_drained(50);
    assert (arrive_cycle.exists(tm) && arrive_cycle[tm] - issue_cycle[tm] == 5)
      else flag_error("multiply latency is not 5 cycles");

    // fill lane 0 so the third issue lands on a full lane
    set_lane_op(0, {exec_cmd_pkg::ALU_OR, 6'd4}, a, b, t0);
    drive_cycle(4'b0001, acc);
    set_lane_op(0, {exec_cmd_pkg::ALU_AND, 6'd5}, a, b, t1);
    drive_cycle(4'b0001, acc);
    set_lane_op(0, {exec_cmd_pkg::ALU_SLT, 6'd6}, a, b, t3);
    drive_cycle(4'b0001, acc);
    assert (lane_full[0] && acc == 4'b0000) else flag_error("issue to full lane 0 accepted");
    for (int n = 0; n < 6 && lane_full[0]; n++) drive_cycle(4'b0000, acc);
    assert (!lane_full[0]) else flag_error("lane 0 stayed full after its grant");
    wait_drained(50);

    // random traffic where a lane rests a cycle after each issue
    prev = '0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      draw_bits(4, r);
      mask = r[3:0] & ~lane_full & ~prev;
      for (int l = 0; l < 4; l++) begin
        if (mask[l]) begin
          draw_bits(10, r);
          cmd = r[9:0];
          if (l != `EXEC_MUL_LANE) cmd[9:6] = 4'(cmd[9:6] % 10);
          draw_bits(64, a);
          draw_bits(2, r);
          if (r[1:0] == 2'b00) b = a;
          else draw_bits(64, b);
          set_lane_op(l, cmd, a, b, t0);
        end
      end
      drive_cycle(mask, acc);
      assert (acc == mask) else flag_error("random issue ignored with credits left");
      prev = mask;
    end
    wait_drained(200);

    foreach (pending[t]) begin
      errors++;
      $display("tag %0d was accepted but never reached the memory stage", t);
    end
    $display("issued=%0d results=%0d ignored=%0d errors=%0d", issued, results, drops, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/exec_cmd_pkg.sv
rtl/exec_pipe_pkg.sv
rtl/exec_result_if.sv
rtl/exec_issue_stage.sv
rtl/exec_alu.sv
rtl/exec_multiplier.sv
rtl/exec_result_buffer.sv
rtl/execute_output_select.sv
rtl/execute_stage_top.sv
testbench/tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the execute-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_execute_stage

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module "$TOP" -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench verdict decides the exit status
if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0
